//--- rtl/isa_pkg.sv
package isa_pkg;

    // Architectural register file shape
    localparam int NUM_ARCH_REGS  = 32;
    localparam int REG_ADDR_WIDTH = $clog2(NUM_ARCH_REGS);

    // Data path width
    localparam int XLEN = 32;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t; // Register index
    typedef logic [XLEN-1:0]           word_t;     // Data word

    // x0 is never renamed and always reads zero
    localparam reg_addr_t ZERO_REG = '0;

endpackage

//--- rtl/ooo_pkg.sv
package ooo_pkg;

    // Reservation-station tag space
    localparam int NUM_TAGS  = 16;
    localparam int TAG_WIDTH = $clog2(NUM_TAGS);

    typedef logic [TAG_WIDTH-1:0] tag_t; // Producer tag

endpackage

//--- rtl/map_lookup_if.sv
`timescale 1ns/1ps

interface map_lookup_if;

    // Lookup requests and rename, from the resolver
    isa_pkg::reg_addr_t rs1;
    isa_pkg::reg_addr_t rs2;
    logic               rename_en;
    isa_pkg::reg_addr_t rename_reg;
    ooo_pkg::tag_t      rename_tag;

    // Lookup results, from the map table
    logic               src1_busy;
    logic               src2_busy;
    ooo_pkg::tag_t      src1_tag;
    ooo_pkg::tag_t      src2_tag;

    modport resolver (
        output rs1, rs2, rename_en, rename_reg, rename_tag,
        input  src1_busy, src2_busy, src1_tag, src2_tag
    );

    // Map table side
    modport tbl (
        input  rs1, rs2, rename_en, rename_reg, rename_tag,
        output src1_busy, src2_busy, src1_tag, src2_tag
    );

endinterface

//--- rtl/map_table.sv
`timescale 1ns/1ps

module map_table (
    input  logic               clock,
    input  logic               reset,
    map_lookup_if.tbl          lookup,
    input  logic               cdb_valid,
    input  ooo_pkg::tag_t      cdb_tag,
    output logic               wb_en,
    output isa_pkg::reg_addr_t wb_reg
);

    logic [isa_pkg::NUM_ARCH_REGS-1:0] busy;                           // Producer in flight
    ooo_pkg::tag_t                     tags [isa_pkg::NUM_ARCH_REGS];  // Latest producer tag

    logic rename_write;

    // Sources see the map as it stands before this cycle's rename
    assign lookup.src1_busy = busy[lookup.rs1];
    assign lookup.src2_busy = busy[lookup.rs2];
    assign lookup.src1_tag  = tags[lookup.rs1];
    assign lookup.src2_tag  = tags[lookup.rs2];

    assign rename_write = lookup.rename_en && (lookup.rename_reg != isa_pkg::ZERO_REG);

    // A busy tag lives in at most one entry, so at most one match
    always_comb begin
        wb_en  = 1'b0;
        wb_reg = isa_pkg::ZERO_REG;
        for (int i = 0; i < isa_pkg::NUM_ARCH_REGS; i++) begin
            if (cdb_valid && busy[i] && (tags[i] == cdb_tag)) begin
                wb_en  = 1'b1;
                wb_reg = isa_pkg::reg_addr_t'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (wb_en) begin
                busy[wb_reg] <= 1'b0; // Producer done
            end
            if (rename_write) begin
                busy[lookup.rename_reg] <= 1'b1; // Rename overrides a same-cycle clear
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rename_write) begin
            tags[lookup.rename_reg] <= lookup.rename_tag;
        end
    end

endmodule

//--- rtl/tag_free_list.sv
`timescale 1ns/1ps

module tag_free_list (
    input  logic          clock,
    input  logic          reset,
    input  logic          alloc_en,
    input  logic          cdb_valid,
    input  ooo_pkg::tag_t cdb_tag,
    output logic          tag_available,
    output ooo_pkg::tag_t alloc_tag
);

    logic [ooo_pkg::NUM_TAGS-1:0] free_bits; // One bit per tag, set when free

    assign tag_available = |free_bits;

    // Lowest free tag wins
    always_comb begin
        alloc_tag = '0;
        for (int i = ooo_pkg::NUM_TAGS - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                alloc_tag = ooo_pkg::tag_t'(i);
            end
        end
    end

    // Returned tag only shows up in alloc_tag from the next cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            free_bits <= '1;
        end else begin
            if (alloc_en && tag_available) begin
                free_bits[alloc_tag] <= 1'b0;
            end
            if (cdb_valid) begin
                free_bits[cdb_tag] <= 1'b1; // Freed even if no map entry matched
            end
        end
    end

endmodule

//--- rtl/arch_reg_file.sv
`timescale 1ns/1ps

module arch_reg_file (
    input  logic               clock,
    input  logic               reset,
    input  isa_pkg::reg_addr_t rd_addr1,
    input  isa_pkg::reg_addr_t rd_addr2,
    output isa_pkg::word_t     rd_data1,
    output isa_pkg::word_t     rd_data2,
    input  logic               wb_en,
    input  isa_pkg::reg_addr_t wb_reg,
    input  isa_pkg::word_t     wb_data
);

    isa_pkg::word_t regs [isa_pkg::NUM_ARCH_REGS];

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    // x0 cleared at reset and never written, so it reads zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < isa_pkg::NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_reg != isa_pkg::ZERO_REG)) begin
            regs[wb_reg] <= wb_data; // CDB writeback
        end
    end

endmodule

//--- rtl/operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_valid,
    input  isa_pkg::reg_addr_t dispatch_rs1,
    input  isa_pkg::reg_addr_t dispatch_rs2,
    input  isa_pkg::reg_addr_t dispatch_rd,
    input  logic               tag_available,
    input  ooo_pkg::tag_t      alloc_tag,
    output logic               alloc_en,
    map_lookup_if.resolver     lookup,
    input  isa_pkg::word_t     rf_data1,
    input  isa_pkg::word_t     rf_data2,
    input  logic               cdb_valid,
    input  ooo_pkg::tag_t      cdb_tag,
    input  isa_pkg::word_t     cdb_value,
    output logic               issue_valid,
    output ooo_pkg::tag_t      issue_tag,
    output logic               src1_ready,
    output logic               src2_ready,
    output ooo_pkg::tag_t      src1_tag,
    output ooo_pkg::tag_t      src2_tag,
    output isa_pkg::word_t     src1_value,
    output isa_pkg::word_t     src2_value
);

    logic accept;

    // Ready when x0, not renamed, or its producer is on the CDB right now
    function automatic logic source_ready(isa_pkg::reg_addr_t addr, logic busy,
                                          ooo_pkg::tag_t tag);
        return (addr == isa_pkg::ZERO_REG) || !busy || (cdb_valid && (cdb_tag == tag));
    endfunction

    function automatic isa_pkg::word_t source_value(isa_pkg::reg_addr_t addr, logic busy,
                                                    ooo_pkg::tag_t tag,
                                                    isa_pkg::word_t rf_data);
        isa_pkg::word_t value;
        value = '0;
        if (addr == isa_pkg::ZERO_REG) begin
            value = '0;
        end else if (!busy) begin
            value = rf_data; // Committed value
        end else if (cdb_valid && (cdb_tag == tag)) begin
            value = cdb_value; // Bypass from the broadcast
        end
        return value;
    endfunction

    assign accept   = dispatch_valid && tag_available;
    assign alloc_en = accept;

    assign lookup.rs1        = dispatch_rs1;
    assign lookup.rs2        = dispatch_rs2;
    assign lookup.rename_en  = accept && (dispatch_rd != isa_pkg::ZERO_REG);
    assign lookup.rename_reg = dispatch_rd;
    assign lookup.rename_tag = alloc_tag;

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept; // One-cycle pulse per accepted dispatch
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            issue_tag  <= alloc_tag;
            src1_ready <= source_ready(dispatch_rs1, lookup.src1_busy, lookup.src1_tag);
            src2_ready <= source_ready(dispatch_rs2, lookup.src2_busy, lookup.src2_tag);
            src1_value <= source_value(dispatch_rs1, lookup.src1_busy, lookup.src1_tag,
                                       rf_data1);
            src2_value <= source_value(dispatch_rs2, lookup.src2_busy, lookup.src2_tag,
                                       rf_data2);
            // Tag is zero once the source is ready
            src1_tag <= source_ready(dispatch_rs1, lookup.src1_busy, lookup.src1_tag)
                        ? '0 : lookup.src1_tag;
            src2_tag <= source_ready(dispatch_rs2, lookup.src2_busy, lookup.src2_tag)
                        ? '0 : lookup.src2_tag;
        end
    end

endmodule

//--- rtl/rename_unit.sv
`timescale 1ns/1ps

module rename_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_valid,
    input  isa_pkg::reg_addr_t dispatch_rs1,
    input  isa_pkg::reg_addr_t dispatch_rs2,
    input  isa_pkg::reg_addr_t dispatch_rd,
    output logic               dispatch_ready,
    input  logic               cdb_valid,
    input  ooo_pkg::tag_t      cdb_tag,
    input  isa_pkg::word_t     cdb_value,
    output logic               issue_valid,
    output ooo_pkg::tag_t      issue_tag,
    output logic               src1_ready,
    output ooo_pkg::tag_t      src1_tag,
    output isa_pkg::word_t     src1_value,
    output logic               src2_ready,
    output ooo_pkg::tag_t      src2_tag,
    output isa_pkg::word_t     src2_value
);

    logic               wb_en;
    isa_pkg::reg_addr_t wb_reg;
    logic               alloc_en;
    ooo_pkg::tag_t      alloc_tag;
    isa_pkg::word_t     rf_data1;
    isa_pkg::word_t     rf_data2;

    map_lookup_if lookup_bus ();

    map_table u_map_table (
        .clock     (clock),
        .reset     (reset),
        .lookup    (lookup_bus.tbl),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg)
    );

    tag_free_list u_tag_free_list (
        .clock         (clock),
        .reset         (reset),
        .alloc_en      (alloc_en),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .tag_available (dispatch_ready), // Back-pressure is just tag availability
        .alloc_tag     (alloc_tag)
    );

    arch_reg_file u_arch_reg_file (
        .clock    (clock),
        .reset    (reset),
        .rd_addr1 (dispatch_rs1),
        .rd_addr2 (dispatch_rs2),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2),
        .wb_en    (wb_en),
        .wb_reg   (wb_reg),
        .wb_data  (cdb_value)
    );

    operand_resolve u_operand_resolve (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_rd    (dispatch_rd),
        .tag_available  (dispatch_ready),
        .alloc_tag      (alloc_tag),
        .alloc_en       (alloc_en),
        .lookup         (lookup_bus.resolver),
        .rf_data1       (rf_data1),
        .rf_data2       (rf_data2),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .issue_valid    (issue_valid),
        .issue_tag      (issue_tag),
        .src1_ready     (src1_ready),
        .src2_ready     (src2_ready),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .src1_value     (src1_value),
        .src2_value     (src2_value)
    );

endmodule

//--- tb/rename_unit_tb.sv
`timescale 1ns/1ps

module rename_unit_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 20;

    // One cycle of stimulus and the issue result expected after its edge
    typedef struct packed {
        int dv, rs1, rs2, rd;   // Dispatch fields
        int cv, ctag;           // CDB broadcast
        int ei, etag;           // Expected issue_valid and issue_tag
        int r1, t1, r2, t2;     // Expected source ready bits and tags
    } row_t;

    logic               clock;
    logic               reset;
    logic               dispatch_valid;
    isa_pkg::reg_addr_t dispatch_rs1;
    isa_pkg::reg_addr_t dispatch_rs2;
    isa_pkg::reg_addr_t dispatch_rd;
    logic               dispatch_ready;
    logic               cdb_valid;
    ooo_pkg::tag_t      cdb_tag;
    isa_pkg::word_t     cdb_value;
    logic               issue_valid;
    ooo_pkg::tag_t      issue_tag;
    logic               src1_ready;
    ooo_pkg::tag_t      src1_tag;
    isa_pkg::word_t     src1_value;
    logic               src2_ready;
    ooo_pkg::tag_t      src2_tag;
    isa_pkg::word_t     src2_value;

    row_t rows [$];
    logic table_loaded = 1'b0;
    int   errors;
    int   seed;

    // Shadow model of registers, map and free list
    isa_pkg::word_t model_regs [isa_pkg::NUM_ARCH_REGS];
    int             model_tags [isa_pkg::NUM_ARCH_REGS];
    logic           model_busy [isa_pkg::NUM_ARCH_REGS];
    logic           model_free [ooo_pkg::NUM_TAGS];

    int             exp_valid, exp_tag, exp_r1, exp_t1, exp_r2, exp_t2;
    isa_pkg::word_t exp_v1, exp_v2;

    rename_unit UUT (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Lowest free tag in the model, -1 when all are in flight
    function automatic int lowest_free();
        int found;
        found = -1;
        for (int i = ooo_pkg::NUM_TAGS - 1; i >= 0; i--) begin
            if (model_free[i]) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic resolve_source(input int addr, input row_t r, input isa_pkg::word_t cval,
                                  output int rdy, output int tag, output isa_pkg::word_t val);
        rdy = 1;
        tag = 0;
        val = '0;
        if (addr != int'(isa_pkg::ZERO_REG)) begin
            if (!model_busy[addr]) begin
                val = model_regs[addr];
            end else if (r.cv != 0 && model_tags[addr] == r.ctag) begin
                val = cval; // Producer broadcasting this cycle
            end else begin
                rdy = 0;
                tag = model_tags[addr];
            end
        end
    endtask

    task automatic predict(input int row, input row_t r, input isa_pkg::word_t cval);
        exp_tag   = lowest_free();
        exp_valid = (r.dv != 0 && exp_tag >= 0) ? 1 : 0;
        resolve_source(r.rs1, r, cval, exp_r1, exp_t1, exp_v1);
        resolve_source(r.rs2, r, cval, exp_r2, exp_t2, exp_v2);
        if (r.ei != exp_valid || (exp_valid != 0 && (r.etag != exp_tag || r.r1 != exp_r1
                || r.r2 != exp_r2 || r.t1 != exp_t1 || r.t2 != exp_t2))) begin
            errors++;
            $display("Table row %0d does not agree with the shadow model", row);
        end
    endtask

    task automatic check_value(input int row, input string name, input logic [31:0] actual,
                               input int expected);
        if (actual !== 32'(expected)) begin
            errors++;
            $display("Error row %0d: %s = %h, expected %h", row, name, actual, 32'(expected));
        end
    endtask

    task automatic check_issue(input int row);
        check_value(row, "issue_valid", 32'(issue_valid), exp_valid);
        if (exp_valid != 0) begin
            check_value(row, "issue_tag", 32'(issue_tag), exp_tag);
            check_value(row, "src1_ready", 32'(src1_ready), exp_r1);
            check_value(row, "src2_ready", 32'(src2_ready), exp_r2);
            if (exp_r1 != 0) begin
                check_value(row, "src1_value", src1_value, int'(exp_v1));
            end else begin
                check_value(row, "src1_tag", 32'(src1_tag), exp_t1);
            end
            if (exp_r2 != 0) begin
                check_value(row, "src2_value", src2_value, int'(exp_v2));
            end else begin
                check_value(row, "src2_tag", 32'(src2_tag), exp_t2);
            end
        end
    endtask

    // Clear before rename, so a same-cycle rename of the register wins
    task automatic update_model(input row_t r, input isa_pkg::word_t cval);
        for (int i = 1; i < isa_pkg::NUM_ARCH_REGS; i++) begin
            if (r.cv != 0 && model_busy[i] && model_tags[i] == r.ctag) begin
                model_regs[i] = cval;
                model_busy[i] = 1'b0;
            end
        end
        if (exp_valid != 0) begin
            model_free[exp_tag] = 1'b0;
        end
        if (r.cv != 0) begin
            model_free[r.ctag] = 1'b1; // Freed even when no entry matched
        end
        if (exp_valid != 0 && r.rd != int'(isa_pkg::ZERO_REG)) begin
            model_busy[r.rd] = 1'b1;
            model_tags[r.rd] = exp_tag;
        end
    endtask

    initial begin
        row_t           r;
        isa_pkg::word_t cval;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        dispatch_rd    = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        errors         = 0;
        seed           = 72208;
        for (int i = 0; i < isa_pkg::NUM_ARCH_REGS; i++) begin
            model_regs[i] = '0;
            model_tags[i] = 0;
            model_busy[i] = 1'b0;
        end
        for (int i = 0; i < ooo_pkg::NUM_TAGS; i++) begin
            model_free[i] = 1'b1;
        end
        //              dv rs1 rs2 rd  cv tag  ei etag r1 t1 r2 t2
        rows.push_back('{1,  1,  2,  3, 0, 0,  1,  0,  1, 0, 1, 0}); // Fresh tags in order
        rows.push_back('{1,  4,  5,  6, 0, 0,  1,  1,  1, 0, 1, 0});
        rows.push_back('{1,  7,  8,  9, 0, 0,  1,  2,  1, 0, 1, 0});
        rows.push_back('{1,  3,  6, 10, 0, 0,  1,  3,  0, 0, 0, 1}); // Reads earlier producers
        rows.push_back('{1,  9,  1,  9, 0, 0,  1,  4,  0, 2, 1, 0}); // rs1 == rd sees older tag
        rows.push_back('{0,  0,  0,  0, 1, 0,  0,  0,  0, 0, 0, 0}); // x3 written back
        rows.push_back('{1,  3,  6, 11, 1, 1,  1,  0,  1, 0, 1, 0}); // RF read and CDB bypass
        rows.push_back('{1,  6, 11, 12, 0, 0,  1,  1,  1, 0, 0, 0});
        rows.push_back('{1,  0,  0, 13, 0, 0,  1,  5,  1, 0, 1, 0});
        rows.push_back('{1, 13,  0, 13, 0, 0,  1,  6,  0, 5, 1, 0}); // x13 renamed twice
        rows.push_back('{0,  0,  0,  0, 1, 5,  0,  0,  0, 0, 0, 0}); // Stale tag, value dropped
        rows.push_back('{1, 13,  0, 14, 0, 0,  1,  5,  0, 6, 1, 0}); // Freed tag reused
        rows.push_back('{0,  0,  0,  0, 1, 6,  0,  0,  0, 0, 0, 0});
        rows.push_back('{1, 13, 14,  0, 0, 0,  1,  6,  1, 0, 0, 5});
        rows.push_back('{1,  0,  0,  0, 0, 0,  1,  7,  1, 0, 1, 0}); // x0 everywhere
        rows.push_back('{1,  0,  3,  0, 0, 0,  1,  8,  1, 0, 1, 0});
        rows.push_back('{1,  0,  5, 15, 0, 0,  1,  9,  1, 0, 1, 0});
        rows.push_back('{1, 15,  0, 16, 0, 0,  1, 10,  0, 9, 1, 0});
        rows.push_back('{1, 16, 15, 17, 0, 0,  1, 11,  0,10, 0, 9});
        rows.push_back('{1,  1,  2, 18, 0, 0,  1, 12,  1, 0, 1, 0});
        rows.push_back('{1,  1,  2, 19, 0, 0,  1, 13,  1, 0, 1, 0});
        rows.push_back('{1,  1,  2, 20, 0, 0,  1, 14,  1, 0, 1, 0});
        rows.push_back('{1,  0, 17, 21, 0, 0,  1, 15,  1, 0, 0,11}); // Last free tag
        rows.push_back('{1, 21,  0, 22, 0, 0,  0,  0,  0, 0, 0, 0}); // Held, no tag
        rows.push_back('{1, 21,  0, 22, 1, 3,  0,  0,  0, 0, 0, 0});
        rows.push_back('{1, 21,  0, 22, 0, 0,  1,  3,  0,15, 1, 0}); // Accepted after the CDB
        rows.push_back('{0,  0,  0,  0, 1,15,  0,  0,  0, 0, 0, 0});
        rows.push_back('{1, 21, 10,  0, 0, 0,  1, 15,  1, 0, 1, 0});
        table_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        foreach (rows[i]) begin
            r              = rows[i];
            cval           = (r.cv != 0) ? $random(seed) : '0;
            dispatch_valid = (r.dv != 0);
            dispatch_rs1   = isa_pkg::reg_addr_t'(r.rs1);
            dispatch_rs2   = isa_pkg::reg_addr_t'(r.rs2);
            dispatch_rd    = isa_pkg::reg_addr_t'(r.rd);
            cdb_valid      = (r.cv != 0);
            cdb_tag        = ooo_pkg::tag_t'(r.ctag);
            cdb_value      = cval;
            predict(i, r, cval);
            check_value(i, "dispatch_ready", 32'(dispatch_ready), (exp_tag >= 0) ? 1 : 0);
            @(posedge clock);
            #DRIVE_DELAY;
            check_issue(i); // Result of the dispatch accepted at this edge
            update_model(r, cval);
        end
        dispatch_valid = 1'b0;
        cdb_valid      = 1'b0;

        $display("Rows applied: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        int limit;
        wait (table_loaded === 1'b1);
        limit = (rows.size() + RESET_CYCLES + MARGIN) * CLK_PERIOD;
        #(limit);
        $display("Timeout: the run did not reach the end of the table in time");
        $display("tests failed");
        $finish;
    end

endmodule

//--- verilog.f
rtl/isa_pkg.sv
rtl/ooo_pkg.sv
rtl/map_lookup_if.sv
rtl/map_table.sv
rtl/tag_free_list.sv
rtl/arch_reg_file.sv
rtl/operand_resolve.sv
rtl/rename_unit.sv
tb/rename_unit_tb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module rename_unit_tb \
    -Mdir obj_dir -o rename_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rename_unit_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
